/* hdl/conv_params.svh */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// unsigned pixel width
`define PIX_WIDTH      8
// signed coefficient width
`define COEF_WIDTH     8
// zero-extended pixel (9b) times coefficient (8b)
`define PROD_WIDTH     17
// nine products plus carry growth
`define SUM_WIDTH      21

// pixels per image row, fixed
`define ROW_LEN        8

// configuration bus
`define CFG_ADDR_WIDTH 4
`define CFG_DATA_WIDTH 16
// coefficient pairs live at 0..4, control word here
`define CTRL_ADDR      8

`endif

/* hdl/conv_pkg.sv */
`include "conv_params.svh"

package conv_pkg;

    ////////////////////////////////////////
    // 3x3 neighbourhood, raster order
    ////////////////////////////////////////
    // row 0 is the oldest row, column 2 the newest pixel
    typedef struct packed {
        logic [`PIX_WIDTH-1:0] r0c0;
        logic [`PIX_WIDTH-1:0] r0c1;
        logic [`PIX_WIDTH-1:0] r0c2;
        logic [`PIX_WIDTH-1:0] r1c0;
        logic [`PIX_WIDTH-1:0] r1c1;
        logic [`PIX_WIDTH-1:0] r1c2;
        logic [`PIX_WIDTH-1:0] r2c0;
        logic [`PIX_WIDTH-1:0] r2c1;
        logic [`PIX_WIDTH-1:0] r2c2;
    } pixWindow_t;

    // coefficients, same layout as the window
    typedef struct packed {
        logic signed [`COEF_WIDTH-1:0] r0c0;
        logic signed [`COEF_WIDTH-1:0] r0c1;
        logic signed [`COEF_WIDTH-1:0] r0c2;
        logic signed [`COEF_WIDTH-1:0] r1c0;
        logic signed [`COEF_WIDTH-1:0] r1c1;
        logic signed [`COEF_WIDTH-1:0] r1c2;
        logic signed [`COEF_WIDTH-1:0] r2c0;
        logic signed [`COEF_WIDTH-1:0] r2c1;
        logic signed [`COEF_WIDTH-1:0] r2c2;
    } kernel_t;

    ////////////////////////////////////////
    // configuration word views
    ////////////////////////////////////////
    // control word, shift in the top nibble
    typedef struct packed {
        logic [3:0]                   shift;
        logic                         absMode;
        logic [`CFG_DATA_WIDTH-6:0]   reserved;
    } ctrl_t;

    // low byte holds the earlier coefficient
    typedef struct packed {
        logic signed [`COEF_WIDTH-1:0] hi;
        logic signed [`COEF_WIDTH-1:0] lo;
    } coefPair_t;

    // decoded by address in the register block
    typedef union packed {
        coefPair_t coef;
        ctrl_t     ctrl;
    } cfgWord_t;

    // quantizer output
    typedef struct packed {
        logic [`PIX_WIDTH-1:0] pixel;
        // raw sum was negative
        logic                  sign;
        // clamp changed the value
        logic                  saturated;
    } convResult_t;

endpackage

/* hdl/kernelRegs.sv */
`timescale 1ns/1ps

`include "conv_params.svh"

module kernelRegs (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        cfgWrite,
    input  logic [`CFG_ADDR_WIDTH-1:0]  cfgAddr,
    input  conv_pkg::cfgWord_t          cfgData,
    output conv_pkg::kernel_t           kernel,
    output conv_pkg::ctrl_t             ctrl
);

    // nine taps, two per address
    localparam int numCoefs = 9;

    // coefficient store in raster order
    logic signed [`COEF_WIDTH-1:0] coefReg [numCoefs];
    // quantizer control
    conv_pkg::ctrl_t               ctrlReg;
    // write hits the control word
    logic                          ctrlHit;

    assign ctrlHit = (cfgAddr == `CFG_ADDR_WIDTH'(`CTRL_ADDR));

    ////////////////////////////////////////
    // register writes
    ////////////////////////////////////////
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // zero kernel, no shift, signed mode
            for (int i = 0; i < numCoefs; i++) begin
                coefReg[i] <= '0;
            end
            ctrlReg <= '0;
        end else if (cfgWrite) begin
            if (ctrlHit) begin
                // control view of the word
                ctrlReg <= cfgData.ctrl;
            end
            // coefficient view, address a covers taps 2a and 2a+1
            // tap 9 does not exist, so the high byte at 4 drops out
            // addresses above 4 match no tap and are ignored
            for (int i = 0; i < numCoefs; i++) begin
                if (int'(cfgAddr) == i / 2) begin
                    if (i % 2 == 0) begin
                        coefReg[i] <= cfgData.coef.lo;
                    end else begin
                        coefReg[i] <= cfgData.coef.hi;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////
    // outputs
    ////////////////////////////////////////
    // taps back into struct order
    assign kernel = '{
        coefReg[0], coefReg[1], coefReg[2],
        coefReg[3], coefReg[4], coefReg[5],
        coefReg[6], coefReg[7], coefReg[8]
    };

    assign ctrl = ctrlReg;

endmodule

/* hdl/lineWindow.sv */
`timescale 1ns/1ps

`include "conv_params.svh"

module lineWindow (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   frameStart,
    input  logic                   pixelValid,
    input  logic [`PIX_WIDTH-1:0]  pixel,
    output logic                   windowValid,
    output conv_pkg::pixWindow_t   window
);

    localparam int colWidth = $clog2(`ROW_LEN);

    // one row back and two rows back
    logic [`PIX_WIDTH-1:0] rowAbove    [`ROW_LEN];
    logic [`PIX_WIDTH-1:0] rowTwoAbove [`ROW_LEN];
    // window taps, [row][col], col 2 newest
    logic [`PIX_WIDTH-1:0] win [3][3];

    // position of the incoming pixel
    logic [colWidth-1:0]   colCount;
    // saturates at 2, only needs to know two rows are behind
    logic [1:0]            rowCount;
    logic                  lastCol;
    logic                  fullWindow;

    assign lastCol    = (colCount == colWidth'(`ROW_LEN - 1));
    // columns 0 and 1 of a row never close a window
    assign fullWindow = (colCount >= colWidth'(2)) && (rowCount == 2'd2);

    ////////////////////////////////////////
    // row delay lines
    ////////////////////////////////////////
    // tail of each line is exactly ROW_LEN pixels old
    always_ff @(posedge clk) begin
        if (pixelValid) begin
            rowAbove[0]    <= pixel;
            rowTwoAbove[0] <= rowAbove[`ROW_LEN-1];
            for (int i = 1; i < `ROW_LEN; i++) begin
                rowAbove[i]    <= rowAbove[i-1];
                rowTwoAbove[i] <= rowTwoAbove[i-1];
            end
        end
    end

    ////////////////////////////////////////
    // 3x3 shift window
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        if (pixelValid) begin
            // older columns move left
            for (int r = 0; r < 3; r++) begin
                win[r][0] <= win[r][1];
                win[r][1] <= win[r][2];
            end
            // fresh column from both delay lines and the input
            win[0][2] <= rowTwoAbove[`ROW_LEN-1];
            win[1][2] <= rowAbove[`ROW_LEN-1];
            win[2][2] <= pixel;
        end
    end

    // position counters and window strobe
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            colCount    <= '0;
            rowCount    <= '0;
            windowValid <= 1'b0;
        end else begin
            // same edge as the window load
            windowValid <= pixelValid && fullWindow && !frameStart;
            if (frameStart) begin
                colCount <= '0;
                rowCount <= '0;
            end else if (pixelValid) begin
                if (lastCol) begin
                    colCount <= '0;
                    if (rowCount != 2'd2) begin
                        rowCount <= rowCount + 2'd1;
                    end
                end else begin
                    colCount <= colCount + colWidth'(1);
                end
            end
        end
    end

    assign window = '{
        win[0][0], win[0][1], win[0][2],
        win[1][0], win[1][1], win[1][2],
        win[2][0], win[2][1], win[2][2]
    };

endmodule

/* hdl/filter3x3.sv */
`timescale 1ns/1ps

`include "conv_params.svh"

module filter3x3 (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          windowValid,
    input  conv_pkg::pixWindow_t          window,
    input  conv_pkg::kernel_t             kernel,
    output logic                          sumValid,
    output logic signed [`SUM_WIDTH-1:0]  sum
);

    // stage 1, captured operands
    conv_pkg::pixWindow_t          winReg;
    conv_pkg::kernel_t             kerReg;
    logic                          loadValid;
    // flat views, index 0 is r0c0
    logic [0:8][`PIX_WIDTH-1:0]    pixTap;
    logic [0:8][`COEF_WIDTH-1:0]   coefTap;
    // stage 2, products
    logic signed [`PROD_WIDTH-1:0] prodReg [9];
    logic                          prodValid;
    // adder tree, one level per row then total
    logic signed [`SUM_WIDTH-1:0]  rowSum [3];
    logic signed [`SUM_WIDTH-1:0]  treeSum;

    assign pixTap  = winReg;
    assign coefTap = kerReg;

    ////////////////////////////////////////
    // payload stages
    ////////////////////////////////////////
    always_ff @(posedge clk) begin
        // load
        if (windowValid) begin
            winReg <= window;
            kerReg <= kernel;
        end
        // multiply, pixel zero-extended to keep it positive
        if (loadValid) begin
            for (int i = 0; i < 9; i++) begin
                prodReg[i] <= $signed({1'b0, pixTap[i]}) * $signed(coefTap[i]);
            end
        end
        // add
        if (prodValid) begin
            sum <= treeSum;
        end
    end

    // products sign-extended before the adds
    always_comb begin
        for (int r = 0; r < 3; r++) begin
            rowSum[r] = `SUM_WIDTH'(prodReg[3*r])
                      + `SUM_WIDTH'(prodReg[3*r+1])
                      + `SUM_WIDTH'(prodReg[3*r+2]);
        end
        treeSum = rowSum[0] + rowSum[1] + rowSum[2];
    end

    ////////////////////////////////////////
    // valid pipe
    ////////////////////////////////////////
    // one bit per stage, windows overlap freely
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            loadValid <= 1'b0;
            prodValid <= 1'b0;
            sumValid  <= 1'b0;
        end else begin
            loadValid <= windowValid;
            prodValid <= loadValid;
            sumValid  <= prodValid;
        end
    end

endmodule

/* hdl/outputQuantizer.sv */
`timescale 1ns/1ps

`include "conv_params.svh"

module outputQuantizer (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          sumValid,
    input  logic signed [`SUM_WIDTH-1:0]  sum,
    input  conv_pkg::ctrl_t               ctrl,
    output logic                          resultValid,
    output conv_pkg::convResult_t         result
);

    localparam int pixMax = (1 << `PIX_WIDTH) - 1;

    logic                         negative;
    logic signed [`SUM_WIDTH-1:0] magnitude;
    logic signed [`SUM_WIDTH-1:0] shifted;
    conv_pkg::convResult_t        nextResult;

    // sign, optional abs, arithmetic shift, clamp
    always_comb begin
        negative   = sum[`SUM_WIDTH-1];
        // sum range keeps the negation from overflowing
        magnitude  = (ctrl.absMode && negative) ? -sum : sum;
        shifted    = magnitude >>> ctrl.shift;
        nextResult.sign = negative;
        if (shifted < 0) begin
            nextResult.pixel     = '0;
            nextResult.saturated = 1'b1;
        end else if (shifted > pixMax) begin
            nextResult.pixel     = `PIX_WIDTH'(pixMax);
            nextResult.saturated = 1'b1;
        end else begin
            nextResult.pixel     = shifted[`PIX_WIDTH-1:0];
            nextResult.saturated = 1'b0;
        end
    end

    // output register
    always_ff @(posedge clk) begin
        if (sumValid) begin
            result <= nextResult;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= sumValid;
        end
    end

endmodule

/* hdl/convTop.sv */
`timescale 1ns/1ps

`include "conv_params.svh"

module convTop (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        frameStart,
    input  logic                        pixelValid,
    input  logic [`PIX_WIDTH-1:0]       pixel,
    input  logic                        cfgWrite,
    input  logic [`CFG_ADDR_WIDTH-1:0]  cfgAddr,
    input  logic [`CFG_DATA_WIDTH-1:0]  cfgData,
    output logic                        resultValid,
    output conv_pkg::convResult_t       result
);

    ////////////////////////////////////////
    // internal links
    ////////////////////////////////////////
    conv_pkg::kernel_t            kernel;
    conv_pkg::ctrl_t              ctrl;
    logic                         windowValid;
    conv_pkg::pixWindow_t         window;
    logic                         sumValid;
    logic signed [`SUM_WIDTH-1:0] sum;

    // coefficients and control word
    kernelRegs i_kernelRegs (
        .clk      (clk),
        .rst      (rst),
        .cfgWrite (cfgWrite),
        .cfgAddr  (cfgAddr),
        .cfgData  (cfgData),
        .kernel   (kernel),
        .ctrl     (ctrl)
    );

    // pixel stream to windows, 1 cycle
    lineWindow i_lineWindow (
        .clk         (clk),
        .rst         (rst),
        .frameStart  (frameStart),
        .pixelValid  (pixelValid),
        .pixel       (pixel),
        .windowValid (windowValid),
        .window      (window)
    );

    // multiply and add, 3 cycles
    filter3x3 i_filter3x3 (
        .clk         (clk),
        .rst         (rst),
        .windowValid (windowValid),
        .window      (window),
        .kernel      (kernel),
        .sumValid    (sumValid),
        .sum         (sum)
    );

    // back to 8 bits, 1 cycle
    outputQuantizer i_outputQuantizer (
        .clk         (clk),
        .rst         (rst),
        .sumValid    (sumValid),
        .sum         (sum),
        .ctrl        (ctrl),
        .resultValid (resultValid),
        .result      (result)
    );

endmodule

/* verification/conv_assert.sv */
`timescale 1ns/1ps

module convAssert (
    input logic                  clk,
    input logic                  rst,
    input logic                  pixelValid,
    input logic                  resultValid,
    input conv_pkg::convResult_t result
);

    ////////////////////////////////////////
    // output strobe
    ////////////////////////////////////////
    // no result while reset is held
    resetQuiet: assert property (@(posedge clk) rst |-> !resultValid)
        else $error("resultValid high during reset");

    // fixed 5-cycle latency from the completing pixel
    latencyFive: assert property (@(posedge clk) disable iff (rst)
        resultValid |-> $past(pixelValid, 5))
        else $error("resultValid without pixelValid 5 cycles earlier");

    ////////////////////////////////////////
    // result payload
    ////////////////////////////////////////
    // zero clamp only for negative sums
    clampLow: assert property (@(posedge clk) disable iff (rst)
        (resultValid && result.saturated && (result.pixel == 8'h00)) |-> result.sign)
        else $error("zero clamp on a non-negative sum");

    // positive overflow always lands on full scale
    clampHigh: assert property (@(posedge clk) disable iff (rst)
        (resultValid && result.saturated && !result.sign) |-> (result.pixel == 8'hff))
        else $error("positive clamp not at 255");

endmodule

bind convTop convAssert i_convAssert (
    .clk         (clk),
    .rst         (rst),
    .pixelValid  (pixelValid),
    .resultValid (resultValid),
    .result      (result)
);

/* verification/convTb.sv */
`timescale 1ns/1ps

`include "conv_params.svh"

module convTb;

    // full windows per row
    localparam int resultsPerRow = `ROW_LEN - 2;
    // cycles allowed for one result to show up
    localparam int waitLimit     = 200;
    // well past the 5-cycle pipeline
    localparam int drainCycles   = 12;

    logic                       clk;
    logic                       rst;
    logic                       frameStart;
    logic                       pixelValid;
    logic [`PIX_WIDTH-1:0]      pixel;
    logic                       cfgWrite;
    logic [`CFG_ADDR_WIDTH-1:0] cfgAddr;
    logic [`CFG_DATA_WIDTH-1:0] cfgData;
    logic                       resultValid;
    conv_pkg::convResult_t      result;

    // DUT results, oldest first
    conv_pkg::convResult_t gotQueue [$];
    int                    seed = 83074;
    // frame currently being checked
    bit                    frameOpen;
    int                    frameRows;
    int                    frameResults;

    convTop i_convTop (
        .clk         (clk),
        .rst         (rst),
        .frameStart  (frameStart),
        .pixelValid  (pixelValid),
        .pixel       (pixel),
        .cfgWrite    (cfgWrite),
        .cfgAddr     (cfgAddr),
        .cfgData     (cfgData),
        .resultValid (resultValid),
        .result      (result)
    );

    // 8 ns clock
    initial begin
        clk = 1'b0;
        forever begin
            #4 clk = ~clk;
        end
    end

    // result monitor
    always @(posedge clk) begin
        if (resultValid) begin
            gotQueue.push_back(result);
        end
    end

    ////////////////////////////////////////
    // helpers
    ////////////////////////////////////////
    task automatic checkValue(input string what, input int got, input int expected);
        if (got != expected) begin
            $display("FAIL at time %0t: %s is %0d, expected %0d", $time, what, got, expected);
            $display("Something failed");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic idleCycles(input int count);
        repeat (count) begin
            @(posedge clk);
        end
    endtask

    task automatic writeConfig(input int addr, input int data);
        @(posedge clk);
        cfgWrite <= 1'b1;
        cfgAddr  <= `CFG_ADDR_WIDTH'(addr);
        cfgData  <= `CFG_DATA_WIDTH'(data);
        @(posedge clk);
        cfgWrite <= 1'b0;
    endtask

    // one-cycle pulse ahead of the first pixel
    task automatic startFrame();
        @(posedge clk);
        frameStart <= 1'b1;
        pixelValid <= 1'b0;
        @(posedge clk);
        frameStart <= 1'b0;
    endtask

    // up to 3 idle cycles before the pixel in gap mode
    task automatic sendPixel(input int value, input bit gaps);
        int idle;
        idle = gaps ? ($random(seed) & 3) : 0;
        repeat (idle) begin
            @(posedge clk);
            pixelValid <= 1'b0;
        end
        @(posedge clk);
        pixelValid <= 1'b1;
        pixel      <= `PIX_WIDTH'(value);
    endtask

    task automatic stopPixels();
        @(posedge clk);
        pixelValid <= 1'b0;
    endtask

    task automatic waitResult();
        int cycles;
        cycles = 0;
        while (gotQueue.size() == 0 && cycles < waitLimit) begin
            @(posedge clk);
            cycles++;
        end
        if (gotQueue.size() == 0) begin
            $display("timeout at time %0t: an expected result never came out", $time);
            $display("Something failed");
            $fatal(1, "result timeout");
        end
    endtask

    // token is pixel byte then flags, sign in bit 1, saturated in bit 0
    task automatic expectResult(input logic [11:0] token);
        conv_pkg::convResult_t got;
        waitResult();
        got = gotQueue.pop_front();
        checkValue("result pixel", got.pixel, token[11:4]);
        checkValue("result sign", got.sign, token[1]);
        checkValue("result saturated flag", got.saturated, token[0]);
        frameResults++;
    endtask

    // result count per frame, then silence
    task automatic closeFrame();
        if (frameOpen) begin
            checkValue("results in frame", frameResults, resultsPerRow * (frameRows - 2));
            idleCycles(drainCycles);
            checkValue("extra results after frame", gotQueue.size(), 0);
            frameOpen = 1'b0;
        end
    endtask

    ////////////////////////////////////////
    // file-driven sequence
    ////////////////////////////////////////
    initial begin
        int                    fd;
        int                    n;
        string                 line;
        int                    addr;
        int                    data;
        int                    gapMode;
        logic [`PIX_WIDTH-1:0] rowPix [`ROW_LEN];
        logic [11:0]           expTok [resultsPerRow];

        rst          = 1'b1;
        frameStart   = 1'b0;
        pixelValid   = 1'b0;
        pixel        = '0;
        cfgWrite     = 1'b0;
        cfgAddr      = '0;
        cfgData      = '0;
        frameOpen    = 1'b0;
        frameRows    = 0;
        frameResults = 0;
        gapMode      = 0;
        repeat (3) begin
            @(posedge clk);
        end
        rst <= 1'b0;

        // idle pipeline stays quiet
        idleCycles(drainCycles);
        checkValue("results from idle DUT", gotQueue.size(), 0);

        fd = $fopen("verification/conv_tests.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("Something failed");
            $fatal(1, "missing test data");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            case (line.getc(0))
                "K": begin
                    closeFrame();
                    n = $sscanf(line, "K %h %h", addr, data);
                    checkValue("fields on config line", n, 2);
                    writeConfig(addr, data);
                end
                "F": begin
                    closeFrame();
                    n = $sscanf(line, "F %d %d", frameRows, gapMode);
                    checkValue("fields on frame line", n, 2);
                    frameOpen    = 1'b1;
                    frameResults = 0;
                    startFrame();
                end
                "P": begin
                    n = $sscanf(line, "P %h %h %h %h %h %h %h %h",
                                rowPix[0], rowPix[1], rowPix[2], rowPix[3],
                                rowPix[4], rowPix[5], rowPix[6], rowPix[7]);
                    checkValue("pixels on row line", n, `ROW_LEN);
                    for (int i = 0; i < `ROW_LEN; i++) begin
                        sendPixel(rowPix[i], gapMode != 0);
                    end
                end
                "E": begin
                    stopPixels();
                    n = $sscanf(line, "E %h %h %h %h %h %h",
                                expTok[0], expTok[1], expTok[2],
                                expTok[3], expTok[4], expTok[5]);
                    checkValue("results on expect line", n, resultsPerRow);
                    for (int i = 0; i < resultsPerRow; i++) begin
                        expectResult(expTok[i]);
                    end
                end
                default: begin
                    // comment or blank line
                end
            endcase
        end
        closeFrame();
        $fclose(fd);
        $display("Everything OK");
        $finish;
    end

endmodule

/* verification/conv_tests.txt */
# K addr data (hex) | F rows gaps | P one row of 8 pixels (hex) | E six results
# result token is hex: pixel byte, then flag digit = sign*2 + saturated
F 3 0
P 10 20 30 40 50 60 70 80
P 08 18 28 38 48 58 68 78
P ff f0 e0 d0 c0 b0 a0 90
E 000 000 000 000 000 000
K 2 0001
F 4 0
P 10 20 30 40 50 60 70 80
P 08 18 28 38 48 58 68 78
P ff f0 e0 d0 c0 b0 a0 90
P 01 02 03 04 05 06 07 08
E 180 280 380 480 580 680
E f00 e00 d00 c00 b00 a00
K 0 0101
K 1 0101
K 2 0101
K 3 0101
K 4 7f01
K 8 3000
F 3 0
P ff ff ff ff 00 00 00 00
P ff ff ff ff 00 00 00 00
P ff ff ff ff 00 00 00 00
E ff1 ff1 bf0 5f0 000 000
K 0 00ff
K 1 fe01
K 2 0200
K 3 00ff
K 4 0001
K 8 0000
F 3 0
P 00 10 20 30 20 10 00 00
P 00 40 80 c0 80 40 00 00
P 00 10 20 30 20 10 00 00
E ff1 ff1 000 003 003 003
K 8 0800
F 3 0
P 00 10 20 30 20 10 00 00
P 00 40 80 c0 80 40 00 00
P 00 10 20 30 20 10 00 00
E ff1 ff1 000 ff3 ff3 a02
F 3 1
P 00 10 20 30 20 10 00 00
P 00 40 80 c0 80 40 00 00
P 00 10 20 30 20 10 00 00
E ff1 ff1 000 ff3 ff3 a02

/* list.f */
+incdir+hdl
hdl/conv_pkg.sv
hdl/kernelRegs.sv
hdl/lineWindow.sv
hdl/filter3x3.sv
hdl/outputQuantizer.sv
hdl/convTop.sv
verification/conv_assert.sv
verification/convTb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
    --top-module convTb -f list.f -o convSim
./obj_dir/convSim | tee sim.log

if grep -q "Something failed" sim.log; then
    echo "simulation failed"
    exit 1
fi
if ! grep -q "Everything OK" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi
echo "simulation passed"
